/* logic/fifo_width_pkg.sv */
package fifo_width_pkg;

   // write side carries whole words
   localparam int W_DATA_W = 32;

   // read side takes one byte per access
   localparam int R_DATA_W = 8;

   // byte lanes per written word
   localparam int LANES = W_DATA_W / R_DATA_W;

   // bits needed to pick one lane out of a word
   localparam int LANE_SEL_W = $clog2(LANES);

   // one stored word, seen whole on the write side and as byte lanes on the read side
   // lane 0 sits in bits 7:0 and leaves the FIFO first
   typedef union packed {
      logic [W_DATA_W-1:0]              word;
      logic [LANES-1:0][R_DATA_W-1:0]   lane;
   } wide_word_u;

endpackage

/* logic/fifo_ptr_pkg.sv */
package fifo_ptr_pkg;

   // byte address into the storage, 16 bytes
   localparam int ADDR_W = 4;

   // word address, four bytes per word
   localparam int W_ADDR_W = ADDR_W - 2;

   // read side addresses single bytes
   localparam int R_ADDR_W = ADDR_W;

   // pointers carry one extra wrap bit
   localparam int W_PTR_W = W_ADDR_W + 1;
   localparam int R_PTR_W = R_ADDR_W + 1;

   // levels count bytes, 0 up to FIFO_SIZE
   localparam int LEVEL_W = ADDR_W + 1;

   // capacity and per-access steps, all in bytes
   localparam logic [LEVEL_W-1:0] FIFO_SIZE = LEVEL_W'(16);
   localparam logic [LEVEL_W-1:0] W_INCR    = LEVEL_W'(4);
   localparam logic [LEVEL_W-1:0] R_INCR    = LEVEL_W'(1);

   // flops in each pointer crossing
   localparam int SYNC_STAGES = 2;

endpackage

/* logic/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync #(
   parameter int PTR_W = 3
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [PTR_W-1:0] gray_i,
   output logic [PTR_W-1:0] bin_o
);

   // stage 0 takes the foreign pointer, the last stage is safe to use
   logic [fifo_ptr_pkg::SYNC_STAGES-1:0][PTR_W-1:0] sync_q;
   logic [PTR_W-1:0] gray_sync;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[fifo_ptr_pkg::SYNC_STAGES-2:0], gray_i};
      end
   end

   assign gray_sync = sync_q[fifo_ptr_pkg::SYNC_STAGES-1];

   // gray to binary, each bit is the xor of all gray bits at or above it
   always_comb begin
      for (int i = 0; i < PTR_W; i++) begin
         bin_o[i] = ^(gray_sync >> i);
      end
   end

endmodule

/* logic/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl (
   input  logic                               w_clk_i,
   input  logic                               rst_n_i,
   input  logic                               w_en_i,
   // read pointer in bytes, already in this domain
   input  logic [fifo_ptr_pkg::R_PTR_W-1:0]   rd_ptr_bin_i,
   output logic [fifo_ptr_pkg::W_PTR_W-1:0]   wr_ptr_gray_o,
   output logic [fifo_ptr_pkg::W_ADDR_W-1:0]  wr_addr_o,
   output logic                               wr_accept_o,
   output logic                               w_full_o,
   output logic                               w_empty_o,
   output logic [fifo_ptr_pkg::LEVEL_W-1:0]   w_level_o
);

   // binary word counter and its successor
   logic [fifo_ptr_pkg::W_PTR_W-1:0] wr_bin;
   logic [fifo_ptr_pkg::W_PTR_W-1:0] wr_bin_nxt;

   // write pointer scaled to bytes
   logic [fifo_ptr_pkg::LEVEL_W-1:0] wr_byte_ptr;

   // writes into a full FIFO are dropped here
   assign wr_accept_o = w_en_i & ~w_full_o;

   assign wr_bin_nxt = wr_bin + 1'b1;

   // binary and gray copies move together, gray is the one that crosses
   always_ff @(posedge w_clk_i) begin
      if (!rst_n_i) begin
         wr_bin        <= '0;
         wr_ptr_gray_o <= '0;
      end else if (wr_accept_o) begin
         wr_bin        <= wr_bin_nxt;
         wr_ptr_gray_o <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
   end

   // wrap bit dropped for the storage index
   assign wr_addr_o = wr_bin[fifo_ptr_pkg::W_ADDR_W-1:0];

   // one word is four bytes
   assign wr_byte_ptr = {wr_bin, {(fifo_ptr_pkg::ADDR_W - fifo_ptr_pkg::W_ADDR_W){1'b0}}};

   // stale read pointer makes this level pessimistic, never below the real fill
   assign w_level_o = wr_byte_ptr - rd_ptr_bin_i;

   // full once another whole word no longer fits
   assign w_full_o  = (w_level_o > (fifo_ptr_pkg::FIFO_SIZE - fifo_ptr_pkg::W_INCR));

   // empty while less than one word is held
   assign w_empty_o = (w_level_o < fifo_ptr_pkg::W_INCR);

endmodule

/* logic/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl (
   input  logic                               r_clk_i,
   input  logic                               rst_n_i,
   input  logic                               r_en_i,
   // write pointer in words, already in this domain
   input  logic [fifo_ptr_pkg::W_PTR_W-1:0]   wr_ptr_bin_i,
   output logic [fifo_ptr_pkg::R_PTR_W-1:0]   rd_ptr_gray_o,
   output logic [fifo_ptr_pkg::R_ADDR_W-1:0]  rd_addr_o,
   output logic                               rd_accept_o,
   output logic                               r_empty_o,
   output logic                               r_full_o,
   output logic [fifo_ptr_pkg::LEVEL_W-1:0]   r_level_o
);

   // binary byte counter and its successor
   logic [fifo_ptr_pkg::R_PTR_W-1:0] rd_bin;
   logic [fifo_ptr_pkg::R_PTR_W-1:0] rd_bin_nxt;

   // incoming word pointer scaled to bytes
   logic [fifo_ptr_pkg::LEVEL_W-1:0] wr_byte_ptr;

   // reads from an empty FIFO are dropped here
   assign rd_accept_o = r_en_i & ~r_empty_o;

   assign rd_bin_nxt = rd_bin + 1'b1;

   // the gray copy is registered so the crossing sees clean single-bit steps
   always_ff @(posedge r_clk_i) begin
      if (!rst_n_i) begin
         rd_bin        <= '0;
         rd_ptr_gray_o <= '0;
      end else if (rd_accept_o) begin
         rd_bin        <= rd_bin_nxt;
         rd_ptr_gray_o <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
   end

   // upper bits pick the word, low bits pick the lane
   assign rd_addr_o = rd_bin[fifo_ptr_pkg::R_ADDR_W-1:0];

   // write side counts words, level arithmetic is in bytes
   assign wr_byte_ptr = {wr_ptr_bin_i,
                         {(fifo_ptr_pkg::ADDR_W - fifo_ptr_pkg::W_ADDR_W){1'b0}}};

   // lagging write pointer keeps this level at or below the real fill
   assign r_level_o = wr_byte_ptr - rd_bin;

   // nothing readable below one byte
   assign r_empty_o = (r_level_o < fifo_ptr_pkg::R_INCR);

   // full from the read side means every byte slot is taken
   assign r_full_o  = (r_level_o > (fifo_ptr_pkg::FIFO_SIZE - fifo_ptr_pkg::R_INCR));

endmodule

/* logic/fifo_asym_mem.sv */
`timescale 1ns/1ps

module fifo_asym_mem (
   // write port, whole words
   input  logic                                   w_clk_i,
   input  logic                                   wr_accept_i,
   input  logic [fifo_ptr_pkg::W_ADDR_W-1:0]      wr_addr_i,
   input  logic [fifo_width_pkg::W_DATA_W-1:0]    w_data_i,
   // read port, single bytes
   input  logic                                   r_clk_i,
   input  logic                                   rst_n_i,
   input  logic                                   rd_accept_i,
   input  logic [fifo_ptr_pkg::ADDR_W-1:0]        rd_addr_i,
   output logic [fifo_width_pkg::R_DATA_W-1:0]    r_data_o
);

   // four word entries
   fifo_width_pkg::wide_word_u mem [0:(1 << fifo_ptr_pkg::W_ADDR_W)-1];

   // byte address split into word index and lane
   logic [fifo_ptr_pkg::W_ADDR_W-1:0]     rd_word;
   logic [fifo_width_pkg::LANE_SEL_W-1:0] rd_lane;

   // output byte register
   logic [fifo_width_pkg::R_DATA_W-1:0]   r_data_q;

   // whole word written at once
   always_ff @(posedge w_clk_i) begin
      if (wr_accept_i) begin
         mem[wr_addr_i].word <= w_data_i;
      end
   end

   assign rd_word = rd_addr_i[fifo_ptr_pkg::ADDR_W-1:fifo_width_pkg::LANE_SEL_W];
   assign rd_lane = rd_addr_i[fifo_width_pkg::LANE_SEL_W-1:0];

   // byte shows one edge after the read is taken, then holds
   always_ff @(posedge r_clk_i) begin
      if (!rst_n_i) begin
         r_data_q <= '0;
      end else if (rd_accept_i) begin
         r_data_q <= mem[rd_word].lane[rd_lane];
      end
   end

   assign r_data_o = r_data_q;

endmodule

/* logic/async_fifo_top.sv */
`timescale 1ns/1ps

module async_fifo_top (
   // write domain
   input  logic                                 w_clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 w_en_i,
   input  logic [fifo_width_pkg::W_DATA_W-1:0]  w_data_i,
   output logic                                 w_full_o,
   output logic                                 w_empty_o,
   output logic [fifo_ptr_pkg::LEVEL_W-1:0]     w_level_o,
   // read domain
   input  logic                                 r_clk_i,
   input  logic                                 r_en_i,
   output logic [fifo_width_pkg::R_DATA_W-1:0]  r_data_o,
   output logic                                 r_empty_o,
   output logic                                 r_full_o,
   output logic [fifo_ptr_pkg::LEVEL_W-1:0]     r_level_o
);

   // write pointer, gray at the source and binary after crossing
   logic [fifo_ptr_pkg::W_PTR_W-1:0]  wr_ptr_gray;
   logic [fifo_ptr_pkg::W_PTR_W-1:0]  wr_ptr_bin_rd;

   // read pointer, same pair in the other direction
   logic [fifo_ptr_pkg::R_PTR_W-1:0]  rd_ptr_gray;
   logic [fifo_ptr_pkg::R_PTR_W-1:0]  rd_ptr_bin_wr;

   // storage access
   logic [fifo_ptr_pkg::W_ADDR_W-1:0] wr_addr;
   logic                              wr_accept;
   logic [fifo_ptr_pkg::R_ADDR_W-1:0] rd_addr;
   logic                              rd_accept;

   fifo_wr_ctrl u_wr_ctrl (
      .w_clk_i       (w_clk_i),
      .rst_n_i       (rst_n_i),
      .w_en_i        (w_en_i),
      .rd_ptr_bin_i  (rd_ptr_bin_wr),
      .wr_ptr_gray_o (wr_ptr_gray),
      .wr_addr_o     (wr_addr),
      .wr_accept_o   (wr_accept),
      .w_full_o      (w_full_o),
      .w_empty_o     (w_empty_o),
      .w_level_o     (w_level_o)
   );

   // write pointer into the read clock
   gray_ptr_sync #(
      .PTR_W (fifo_ptr_pkg::W_PTR_W)
   ) ptr_sync_w2r (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (wr_ptr_gray),
      .bin_o   (wr_ptr_bin_rd)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .r_clk_i       (r_clk_i),
      .rst_n_i       (rst_n_i),
      .r_en_i        (r_en_i),
      .wr_ptr_bin_i  (wr_ptr_bin_rd),
      .rd_ptr_gray_o (rd_ptr_gray),
      .rd_addr_o     (rd_addr),
      .rd_accept_o   (rd_accept),
      .r_empty_o     (r_empty_o),
      .r_full_o      (r_full_o),
      .r_level_o     (r_level_o)
   );

   // read pointer into the write clock
   gray_ptr_sync #(
      .PTR_W (fifo_ptr_pkg::R_PTR_W)
   ) ptr_sync_r2w (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (rd_ptr_gray),
      .bin_o   (rd_ptr_bin_wr)
   );

   fifo_asym_mem u_mem (
      .w_clk_i     (w_clk_i),
      .wr_accept_i (wr_accept),
      .wr_addr_i   (wr_addr),
      .w_data_i    (w_data_i),
      .r_clk_i     (r_clk_i),
      .rst_n_i     (rst_n_i),
      .rd_accept_i (rd_accept),
      .rd_addr_i   (rd_addr),
      .r_data_o    (r_data_o)
   );

endmodule

/* tests/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb;

   localparam int R_PERIOD_NS = 13;
   localparam int RAND_CYCLES = 2000;
   localparam int POST_CYCLES = 300;
   // fill 4 words plus one dropped, drain 16 bytes plus empty reads, 3 held words
   localparam int TOTAL_TXN   = 5 + 19 + RAND_CYCLES + 3 + POST_CYCLES;
   localparam int TIMEOUT_NS  = TOTAL_TXN * 4 * R_PERIOD_NS + 5000;

   logic                                w_clk_i;
   logic                                r_clk_i;
   logic                                rst_n_i;
   logic                                w_en_i;
   logic [fifo_width_pkg::W_DATA_W-1:0] w_data_i;
   logic                                w_full_o;
   logic                                w_empty_o;
   logic [fifo_ptr_pkg::LEVEL_W-1:0]    w_level_o;
   logic                                r_en_i;
   logic [fifo_width_pkg::R_DATA_W-1:0] r_data_o;
   logic                                r_empty_o;
   logic                                r_full_o;
   logic [fifo_ptr_pkg::LEVEL_W-1:0]    r_level_o;

   // byte queue model, lane 0 of each word pushed first
   logic [fifo_width_pkg::R_DATA_W-1:0] model_q[$];
   logic [fifo_width_pkg::R_DATA_W-1:0] exp_data = '0;
   logic [31:0] rng_state = 32'h5460_8466;
   bit mon_en = 1'b0;
   int words_in = 0;
   int check_cnt = 0;
   int fail_cnt = 0;
   int bound_fail_cnt = 0;

   async_fifo_top UUT (
      .w_clk_i   (w_clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .w_empty_o (w_empty_o),
      .w_level_o (w_level_o),
      .r_clk_i   (r_clk_i),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .r_full_o  (r_full_o),
      .r_level_o (r_level_o)
   );

   initial begin
      w_clk_i = 1'b0;
      forever begin
         #4 w_clk_i = ~w_clk_i;
      end
   end

   // quarter-ns offset keeps every read edge apart from every write edge
   initial begin
      r_clk_i = 1'b0;
      #0.25;
      forever begin
         #6.5 r_clk_i = ~r_clk_i;
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic bit chance(input int pct);
      return (next_rand() % 100) < 32'(pct);
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act, input bit is_bound = 1'b0);
      check_cnt++;
      assert (act === exp) else begin
         fail_cnt++;
         if (is_bound) bound_fail_cnt++;
         $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_bound(input string name, input logic [31:0] level,
                              input logic [31:0] occ, input bit at_least);
      check_cnt++;
      assert (at_least ? (level >= occ) : (level <= occ)) else begin
         fail_cnt++;
         bound_fail_cnt++;
         $display("CHECK FAILED %s: level 0x%0h is %s model occupancy 0x%0h at %0t",
                  name, level, at_least ? "below" : "above", occ, $time);
      end
   endtask

   task automatic report_test(input string name, input int errs);
      $display("test %s finished with %0d errors", name, errs);
   endtask

   // write side, sampled mid-cycle where inputs and flags are settled
   initial begin
      fifo_width_pkg::wide_word_u wr_word;
      int lvl;
      forever begin
         @(negedge w_clk_i);
         if (mon_en) begin
            lvl = int'(w_level_o);
            check_bound("w_level_o", lvl, model_q.size(), 1'b1);
            check_val("w_full_o", 32'(lvl > int'(fifo_ptr_pkg::FIFO_SIZE)
                      - int'(fifo_ptr_pkg::W_INCR)), 32'(w_full_o), 1'b1);
            check_val("w_empty_o", 32'(lvl < int'(fifo_ptr_pkg::W_INCR)),
                      32'(w_empty_o), 1'b1);
            if (w_en_i && !w_full_o) begin
               wr_word.word = w_data_i;
               for (int i = 0; i < fifo_width_pkg::LANES; i++) begin
                  model_q.push_back(wr_word.lane[i]);
               end
               words_in++;
            end
         end
      end
   end

   // read side, r_data_o must still show the last accepted byte
   initial begin
      int lvl;
      forever begin
         @(negedge r_clk_i);
         if (mon_en) begin
            lvl = int'(r_level_o);
            check_bound("r_level_o", lvl, model_q.size(), 1'b0);
            check_val("r_empty_o", 32'(lvl < int'(fifo_ptr_pkg::R_INCR)),
                      32'(r_empty_o), 1'b1);
            check_val("r_full_o", 32'(lvl > int'(fifo_ptr_pkg::FIFO_SIZE)
                      - int'(fifo_ptr_pkg::R_INCR)), 32'(r_full_o), 1'b1);
            check_val("r_data_o", 32'(exp_data), 32'(r_data_o));
            if (r_en_i && !r_empty_o) begin
               assert (model_q.size() != 0) begin
                  exp_data = model_q.pop_front();
               end else begin
                  fail_cnt++;
                  $display("the FIFO accepted a read while no data was written at %0t", $time);
               end
            end
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
      $display("Test failures found");
      $finish;
   end

   task automatic apply_reset();
      @(posedge w_clk_i);
      #1;
      w_en_i = 1'b0;
      @(posedge r_clk_i);
      #1;
      r_en_i  = 1'b0;
      mon_en  = 1'b0;
      rst_n_i = 1'b0;
      repeat (2) @(posedge r_clk_i);
      #1;
      model_q.delete();
      exp_data = '0;
      words_in = 0;
      rst_n_i  = 1'b1;
      mon_en   = 1'b1;
   endtask

   task automatic check_reset_state();
      @(negedge w_clk_i);
      check_val("w_full_o", 0, 32'(w_full_o));
      check_val("w_empty_o", 1, 32'(w_empty_o));
      check_val("w_level_o", 0, 32'(w_level_o));
      @(negedge r_clk_i);
      check_val("r_empty_o", 1, 32'(r_empty_o));
      check_val("r_full_o", 0, 32'(r_full_o));
      check_val("r_level_o", 0, 32'(r_level_o));
      check_val("r_data_o", 0, 32'(r_data_o));
   endtask

   task automatic drain();
      @(posedge r_clk_i);
      #1;
      r_en_i = 1'b1;
      while (model_q.size() != 0) begin
         @(posedge r_clk_i);
         #1;
      end
      r_en_i = 1'b0;
   endtask

   // the read pointer has to cross before the write side sees room
   task automatic wait_write_empty();
      @(negedge w_clk_i);
      while (!w_empty_o) @(negedge w_clk_i);
   endtask

   task automatic run_traffic(input int cycles, input int wr_pct, input int rd_pct);
      bit wr_done;
      wr_done = 1'b0;
      fork
         begin
            for (int i = 0; i < cycles; i++) begin
               @(posedge w_clk_i);
               #1;
               w_en_i   = chance(wr_pct);
               w_data_i = next_rand();
            end
            @(posedge w_clk_i);
            #1;
            w_en_i  = 1'b0;
            wr_done = 1'b1;
         end
         begin
            while (!wr_done) begin
               @(posedge r_clk_i);
               #1;
               r_en_i = chance(rd_pct);
            end
         end
      join
      drain();
   endtask

   initial begin
      int fails_at;
      int bounds_at;
      rst_n_i  = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;

      fails_at = fail_cnt;
      apply_reset();
      check_reset_state();
      report_test("1 reset state", fail_cnt - fails_at);

      // writes keep coming until full, the extra one must be dropped
      fails_at = fail_cnt;
      @(posedge w_clk_i);
      #1;
      w_en_i   = 1'b1;
      w_data_i = next_rand();
      while (!w_full_o) begin
         @(posedge w_clk_i);
         #1;
         w_data_i = next_rand();
      end
      @(posedge w_clk_i);
      #1;
      w_en_i = 1'b0;
      @(negedge w_clk_i);
      check_val("words_in", 4, words_in);
      check_val("model_bytes", 16, model_q.size());
      check_val("w_level_o", 16, 32'(w_level_o));
      repeat (4) @(negedge r_clk_i);
      check_val("r_full_o", 1, 32'(r_full_o));
      check_val("r_level_o", 16, 32'(r_level_o));
      report_test("2 fill", fail_cnt - fails_at);

      fails_at = fail_cnt;
      drain();
      // a few reads into an empty FIFO
      @(posedge r_clk_i);
      #1;
      r_en_i = 1'b1;
      repeat (3) @(posedge r_clk_i);
      #1;
      r_en_i = 1'b0;
      @(negedge r_clk_i);
      check_val("r_empty_o", 1, 32'(r_empty_o));
      check_val("r_level_o", 0, 32'(r_level_o));
      wait_write_empty();
      check_val("w_level_o", 0, 32'(w_level_o));
      report_test("3 drain", fail_cnt - fails_at);

      fails_at  = fail_cnt;
      bounds_at = bound_fail_cnt;
      run_traffic(RAND_CYCLES, 12, 75);
      report_test("4 random traffic",
                  (fail_cnt - fails_at) - (bound_fail_cnt - bounds_at));
      report_test("5 level and flag bounds", bound_fail_cnt - bounds_at);

      fails_at = fail_cnt;
      wait_write_empty();
      @(posedge w_clk_i);
      #1;
      w_en_i = 1'b1;
      repeat (3) begin
         w_data_i = next_rand();
         @(posedge w_clk_i);
         #1;
      end
      w_en_i = 1'b0;
      repeat (4) @(negedge r_clk_i);
      check_val("model_bytes", 12, model_q.size());
      check_val("r_level_o", 12, 32'(r_level_o));
      apply_reset();
      check_reset_state();
      run_traffic(POST_CYCLES, 12, 75);
      report_test("6 reset mid-run", fail_cnt - fails_at);

      $display("checks run: %0d, checks failed: %0d", check_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* verilog.f */
logic/fifo_width_pkg.sv
logic/fifo_ptr_pkg.sv
logic/gray_ptr_sync.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/fifo_asym_mem.sv
logic/async_fifo_top.sv
tests/async_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dual-clock FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module async_fifo_tb \
   --Mdir obj_dir \
   -o async_fifo_sim \
   -f verilog.f

./obj_dir/async_fifo_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation reported failures"
   exit 1
fi

echo "simulation finished without failures"
